/* common/mdu_macros.svh */
`ifndef MDU_MACROS_SVH
`define MDU_MACROS_SVH

// **************************************************
// widths
// **************************************************

// full data width of the core
`define MDU_XLEN 64

// width of the *w operations
`define MDU_WLEN 32

// **************************************************
// engine iteration counts
// **************************************************

// one bit per cycle over the whole operand
`define MDU_ITERS_D 64
// word forms only need the low half
`define MDU_ITERS_W 32

`endif

/* common/mdu_pkg.sv */
`default_nettype none

`include "mdu_macros.svh"

package mdu_pkg;

	// op codes, same values as funct3 of the M extension
	typedef enum logic [2:0] {
		OP_MUL    = 3'b000,
		OP_MULH   = 3'b001,
		OP_MULHSU = 3'b010,
		OP_MULHU  = 3'b011,
		OP_DIV    = 3'b100,
		OP_DIVU   = 3'b101,
		OP_REM    = 3'b110,
		OP_REMU   = 3'b111
	} mdu_op_e;

	// request from the core, valid with start
	typedef struct packed {
		mdu_op_e              op;
		logic                 word;
		logic [`MDU_XLEN-1:0] src_a;
		logic [`MDU_XLEN-1:0] src_b;
	} mdu_req_t;

	// prepared job, shared by both engines and result
	typedef struct packed {
		mdu_op_e              op;
		logic                 word;
		logic [`MDU_XLEN-1:0] mag_a;
		logic [`MDU_XLEN-1:0] mag_b;
		// negate product or quotient
		logic                 neg_res;
		// remainder takes the dividend sign
		logic                 neg_rem;
		logic                 div_zero;
		logic                 overflow;
		// extended rs1, needed by the special cases
		logic [`MDU_XLEN-1:0] dividend;
	} mdu_job_t;

	// product view
	typedef struct packed {
		logic [`MDU_XLEN-1:0] hi;
		logic [`MDU_XLEN-1:0] lo;
	} mdu_prod_t;

	// division view
	typedef struct packed {
		logic [`MDU_XLEN-1:0] quotient;
		logic [`MDU_XLEN-1:0] remainder;
	} mdu_quo_t;

	// raw unsigned engine output, 128 bits either way
	typedef union packed {
		mdu_prod_t prod;
		mdu_quo_t  quo;
	} mdu_raw_u;

endpackage

`default_nettype wire

/* mdu/mdu_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mdu_macros.svh"

module mdu_decode (
	input  logic              clk,
	input  logic              rst,
	input  logic              start,
	input  logic              flush,
	input  mdu_pkg::mdu_req_t req,
	input  logic              done,
	output logic              busy,
	output logic              mul_go,
	output logic              div_go,
	output mdu_pkg::mdu_job_t job
);

	logic                 accept;
	logic                 is_div;
	logic                 a_signed;
	logic                 b_signed;
	logic                 word_eff;
	logic                 neg_a;
	logic                 neg_b;
	logic [`MDU_XLEN-1:0] a_ext;
	logic [`MDU_XLEN-1:0] b_ext;
	logic [`MDU_XLEN-1:0] min_neg;
	mdu_pkg::mdu_job_t    job_next;

	// start during busy or flush is dropped
	assign accept = start & ~busy & ~flush;
	assign is_div = req.op[2];

	// mulhsu: only rs1 signed
	assign a_signed = req.op inside {mdu_pkg::OP_MUL, mdu_pkg::OP_MULH, mdu_pkg::OP_MULHSU,
		mdu_pkg::OP_DIV, mdu_pkg::OP_REM};
	assign b_signed = req.op inside {mdu_pkg::OP_MUL, mdu_pkg::OP_MULH,
		mdu_pkg::OP_DIV, mdu_pkg::OP_REM};

	// word mulh variants run as full width
	assign word_eff = req.word & (is_div | (req.op == mdu_pkg::OP_MUL));

	// **************************************************
	// operand extension and magnitudes
	// **************************************************
	always_comb begin
		a_ext = req.src_a;
		b_ext = req.src_b;
		if (word_eff) begin
			a_ext = {{(`MDU_XLEN-`MDU_WLEN){a_signed & req.src_a[`MDU_WLEN-1]}},
				req.src_a[`MDU_WLEN-1:0]};
			b_ext = {{(`MDU_XLEN-`MDU_WLEN){b_signed & req.src_b[`MDU_WLEN-1]}},
				req.src_b[`MDU_WLEN-1:0]};
		end
	end

	assign neg_a = a_signed & a_ext[`MDU_XLEN-1];
	assign neg_b = b_signed & b_ext[`MDU_XLEN-1];

	// most negative value, sign-extended for word forms
	assign min_neg = word_eff ? {{(`MDU_XLEN-`MDU_WLEN+1){1'b1}}, {(`MDU_WLEN-1){1'b0}}}
		: {1'b1, {(`MDU_XLEN-1){1'b0}}};

	always_comb begin
		job_next.op       = req.op;
		job_next.word     = word_eff;
		// -min stays min, which reads as 2^63 unsigned
		job_next.mag_a    = neg_a ? -a_ext : a_ext;
		job_next.mag_b    = neg_b ? -b_ext : b_ext;
		job_next.neg_res  = neg_a ^ neg_b;
		job_next.neg_rem  = neg_a;
		job_next.div_zero = is_div & (b_ext == '0);
		job_next.overflow = is_div & b_signed & (a_ext == min_neg) & (b_ext == '1);
		job_next.dividend = a_ext;
	end

	// **************************************************
	// control
	// **************************************************
	always_ff @(posedge clk) begin
		if (rst) begin
			busy   <= 1'b0;
			mul_go <= 1'b0;
			div_go <= 1'b0;
		end else begin
			mul_go <= accept & ~is_div;
			div_go <= accept & is_div;
			if (flush)
				busy <= 1'b0;
			else if (accept)
				busy <= 1'b1;
			else if (done)
				busy <= 1'b0;
		end
	end

	// job payload held until the next accept
	always_ff @(posedge clk) begin
		if (accept)
			job <= job_next;
	end

	// done only ends an accepted operation
	done_in_busy: assert property (@(posedge clk) disable iff (rst) done |-> busy);

endmodule

`default_nettype wire

/* mdu/mdu_shift_mul.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mdu_macros.svh"

module mdu_shift_mul (
	input  logic              clk,
	input  logic              rst,
	input  logic              flush,
	input  logic              go,
	input  mdu_pkg::mdu_job_t job,
	output logic              fin,
	output mdu_pkg::mdu_raw_u raw
);

	logic                     running;
	logic [6:0]               cnt;
	// full 128-bit accumulator and shifted multiplicand
	logic [2*`MDU_XLEN-1:0]   acc;
	logic [2*`MDU_XLEN-1:0]   mcand;
	logic [`MDU_XLEN-1:0]     mplier;

	// **************************************************
	// iteration control
	// **************************************************
	always_ff @(posedge clk) begin
		if (rst) begin
			running <= 1'b0;
			cnt     <= '0;
			fin     <= 1'b0;
		end else begin
			fin <= 1'b0;
			if (flush) begin
				running <= 1'b0;
			end else if (go) begin
				running <= 1'b1;
				cnt     <= job.word ? 7'(`MDU_ITERS_W) : 7'(`MDU_ITERS_D);
			end else if (running) begin
				cnt <= cnt - 7'd1;
				// last bit, product valid with fin
				if (cnt == 7'd1) begin
					running <= 1'b0;
					fin     <= 1'b1;
				end
			end
		end
	end

	// **************************************************
	// datapath, one multiplier bit per cycle
	// **************************************************
	always_ff @(posedge clk) begin
		if (go) begin
			acc    <= '0;
			mcand  <= {{`MDU_XLEN{1'b0}}, job.mag_a};
			mplier <= job.mag_b;
		end else if (running) begin
			if (mplier[0])
				acc <= acc + mcand;
			mcand  <= mcand << 1;
			mplier <= mplier >> 1;
		end
	end

	always_comb begin
		raw.prod.hi = acc[2*`MDU_XLEN-1:`MDU_XLEN];
		raw.prod.lo = acc[`MDU_XLEN-1:0];
	end

	// decode must hold off until the previous job ends
	mul_go_idle: assert property (@(posedge clk) disable iff (rst) go |-> !running);

endmodule

`default_nettype wire

/* mdu/mdu_restoring_div.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mdu_macros.svh"

module mdu_restoring_div (
	input  logic              clk,
	input  logic              rst,
	input  logic              flush,
	input  logic              go,
	input  mdu_pkg::mdu_job_t job,
	output logic              fin,
	output mdu_pkg::mdu_raw_u raw
);

	logic                 running;
	logic [6:0]           cnt;
	// partial remainder, quotient/dividend shift reg, divisor
	logic [`MDU_XLEN-1:0] rem;
	logic [`MDU_XLEN-1:0] quo;
	logic [`MDU_XLEN-1:0] dvsr;
	logic [`MDU_XLEN:0]   r_shift;
	logic                 fits;

	// **************************************************
	// iteration control
	// **************************************************
	always_ff @(posedge clk) begin
		if (rst) begin
			running <= 1'b0;
			cnt     <= '0;
			fin     <= 1'b0;
		end else begin
			fin <= 1'b0;
			if (flush) begin
				running <= 1'b0;
			end else if (go) begin
				running <= 1'b1;
				cnt     <= job.word ? 7'(`MDU_ITERS_W) : 7'(`MDU_ITERS_D);
			end else if (running) begin
				cnt <= cnt - 7'd1;
				if (cnt == 7'd1) begin
					running <= 1'b0;
					fin     <= 1'b1;
				end
			end
		end
	end

	// **************************************************
	// restoring step
	// **************************************************

	// next dividend bit enters from the top of quo
	assign r_shift = {rem, quo[`MDU_XLEN-1]};
	assign fits    = r_shift >= {1'b0, dvsr};

	always_ff @(posedge clk) begin
		if (go) begin
			rem  <= '0;
			dvsr <= job.mag_b;
			// word dividend left-aligned, 32 steps drain it
			if (job.word)
				quo <= {job.mag_a[`MDU_WLEN-1:0], {(`MDU_XLEN-`MDU_WLEN){1'b0}}};
			else
				quo <= job.mag_a;
		end else if (running) begin
			// zero divisor always fits, so quotient fills with ones
			if (fits)
				rem <= `MDU_XLEN'(r_shift - {1'b0, dvsr});
			else
				rem <= r_shift[`MDU_XLEN-1:0];
			quo <= {quo[`MDU_XLEN-2:0], fits};
		end
	end

	always_comb begin
		raw.quo.quotient  = quo;
		raw.quo.remainder = rem;
	end

	div_go_idle: assert property (@(posedge clk) disable iff (rst) go |-> !running);

endmodule

`default_nettype wire

/* mdu/mdu_result.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mdu_macros.svh"

module mdu_result (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 flush,
	input  logic                 mul_go,
	input  logic                 div_go,
	input  logic                 mul_fin,
	input  logic                 div_fin,
	input  mdu_pkg::mdu_job_t    job,
	input  mdu_pkg::mdu_raw_u    mul_raw,
	input  mdu_pkg::mdu_raw_u    div_raw,
	output logic                 done,
	output logic [`MDU_XLEN-1:0] result
);

	mdu_pkg::mdu_job_t      job_q;
	logic [2*`MDU_XLEN-1:0] prod_s;
	logic [`MDU_XLEN-1:0]   quo_s;
	logic [`MDU_XLEN-1:0]   rem_s;
	logic [`MDU_XLEN-1:0]   val;
	logic [`MDU_XLEN-1:0]   val_ext;

	// job copy for the whole run
	always_ff @(posedge clk) begin
		if (mul_go | div_go)
			job_q <= job;
	end

	// **************************************************
	// sign correction
	// **************************************************

	// whole 128-bit product negated, so hi half is right too
	assign prod_s = job_q.neg_res ? -{mul_raw.prod.hi, mul_raw.prod.lo}
		: {mul_raw.prod.hi, mul_raw.prod.lo};
	assign quo_s  = job_q.neg_res ? -div_raw.quo.quotient : div_raw.quo.quotient;
	assign rem_s  = job_q.neg_rem ? -div_raw.quo.remainder : div_raw.quo.remainder;

	// half select and special cases
	always_comb begin
		case (job_q.op)
			mdu_pkg::OP_MUL:
				val = prod_s[`MDU_XLEN-1:0];
			mdu_pkg::OP_MULH, mdu_pkg::OP_MULHSU, mdu_pkg::OP_MULHU:
				val = prod_s[2*`MDU_XLEN-1:`MDU_XLEN];
			mdu_pkg::OP_DIV, mdu_pkg::OP_DIVU:
				if (job_q.div_zero)
					val = '1;
				else if (job_q.overflow)
					val = job_q.dividend;
				else
					val = quo_s;
			default:
				// rem, remu
				if (job_q.div_zero)
					val = job_q.dividend;
				else if (job_q.overflow)
					val = '0;
				else
					val = rem_s;
		endcase
	end

	// word results sign-extended from bit 31
	assign val_ext = job_q.word ? {{(`MDU_XLEN-`MDU_WLEN){val[`MDU_WLEN-1]}},
		val[`MDU_WLEN-1:0]} : val;

	// **************************************************
	// output registers
	// **************************************************
	always_ff @(posedge clk) begin
		if (rst)
			done <= 1'b0;
		else
			done <= (mul_fin | div_fin) & ~flush;
	end

	// result held until the next done
	always_ff @(posedge clk) begin
		if ((mul_fin | div_fin) & ~flush)
			result <= val_ext;
	end

	done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done);

endmodule

`default_nettype wire

/* rtl/npc_mdu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mdu_macros.svh"

module npc_mdu (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 start,
	input  logic                 flush,
	input  mdu_pkg::mdu_req_t    req,
	output logic                 busy,
	output logic                 done,
	output logic [`MDU_XLEN-1:0] result
);

	mdu_pkg::mdu_job_t job;
	logic              mul_go;
	logic              div_go;
	logic              mul_fin;
	logic              div_fin;
	mdu_pkg::mdu_raw_u mul_raw;
	mdu_pkg::mdu_raw_u div_raw;

	// **************************************************
	// decode, starts one engine per op
	// **************************************************
	mdu_decode i_decode (
		.clk    (clk),
		.rst    (rst),
		.start  (start),
		.flush  (flush),
		.req    (req),
		.done   (done),
		.busy   (busy),
		.mul_go (mul_go),
		.div_go (div_go),
		.job    (job)
	);

	// engines
	mdu_shift_mul i_mul (
		.clk   (clk),
		.rst   (rst),
		.flush (flush),
		.go    (mul_go),
		.job   (job),
		.fin   (mul_fin),
		.raw   (mul_raw)
	);

	mdu_restoring_div i_div (
		.clk   (clk),
		.rst   (rst),
		.flush (flush),
		.go    (div_go),
		.job   (job),
		.fin   (div_fin),
		.raw   (div_raw)
	);

	// sign fix, special values, done
	mdu_result i_result (
		.clk     (clk),
		.rst     (rst),
		.flush   (flush),
		.mul_go  (mul_go),
		.div_go  (div_go),
		.mul_fin (mul_fin),
		.div_fin (div_fin),
		.job     (job),
		.mul_raw (mul_raw),
		.div_raw (div_raw),
		.done    (done),
		.result  (result)
	);

endmodule

`default_nettype wire

/* tests/mdu_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mdu_macros.svh"

module mdu_checker (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 start,
	input  logic                 flush,
	input  mdu_pkg::mdu_req_t    req,
	input  logic                 busy,
	input  logic                 done,
	input  logic [`MDU_XLEN-1:0] result,
	input  logic                 end_test,
	output int                   mismatches,
	output int                   other_errors,
	output int                   checked,
	output int                   flushed,
	output int                   ignored,
	output int                   accepted
);

	// one accepted, not yet finished request
	typedef struct packed {
		mdu_pkg::mdu_req_t    req;
		logic [`MDU_XLEN-1:0] value;
		logic [6:0]           latency;
		logic [31:0]          start_cycle;
	} expect_t;

	expect_t pend[$];
	expect_t head;
	int      cycle    = 0;
	int      n_mis    = 0;
	int      n_other  = 0;
	int      n_check  = 0;
	int      n_flush  = 0;
	int      n_ignore = 0;
	int      n_accept = 0;

	assign mismatches   = n_mis;
	assign other_errors = n_other;
	assign checked      = n_check;
	assign flushed      = n_flush;
	assign ignored      = n_ignore;
	assign accepted     = n_accept;

	// word forms that really run at 32 bits
	function automatic logic short_op(mdu_pkg::mdu_req_t r);
		return r.word && (r.op inside {mdu_pkg::OP_MUL, mdu_pkg::OP_DIV, mdu_pkg::OP_DIVU,
			mdu_pkg::OP_REM, mdu_pkg::OP_REMU});
	endfunction

	// done rises iters + 2 edges after the start edge
	// and is sampled here one edge later
	function automatic logic [6:0] expected_latency(mdu_pkg::mdu_req_t r);
		return short_op(r) ? 7'(`MDU_ITERS_W + 3) : 7'(`MDU_ITERS_D + 3);
	endfunction

	// **************************************************
	// reference model, 128-bit signed arithmetic
	// **************************************************
	function automatic logic [`MDU_XLEN-1:0] expected_value(mdu_pkg::mdu_req_t r);
		logic signed [127:0]  a_s;
		logic signed [127:0]  a_u;
		logic signed [127:0]  b_s;
		logic signed [127:0]  b_u;
		logic signed [127:0]  full;
		logic [`MDU_XLEN-1:0] val;
		if (short_op(r)) begin
			a_s = {{96{r.src_a[31]}}, r.src_a[31:0]};
			b_s = {{96{r.src_b[31]}}, r.src_b[31:0]};
			a_u = {96'b0, r.src_a[31:0]};
			b_u = {96'b0, r.src_b[31:0]};
		end else begin
			a_s = {{64{r.src_a[63]}}, r.src_a};
			b_s = {{64{r.src_b[63]}}, r.src_b};
			a_u = {64'b0, r.src_a};
			b_u = {64'b0, r.src_b};
		end
		// min / -1 fits in 128 bits, low half wraps back to the dividend
		full = '0;
		case (r.op)
			mdu_pkg::OP_MUL:    full = a_s * b_s;
			mdu_pkg::OP_MULH:   full = (a_s * b_s) >>> 64;
			mdu_pkg::OP_MULHSU: full = (a_s * b_u) >>> 64;
			mdu_pkg::OP_MULHU:  full = (a_u * b_u) >>> 64;
			mdu_pkg::OP_DIV:    full = (b_u == 0) ? -128'sd1 : a_s / b_s;
			mdu_pkg::OP_DIVU:   full = (b_u == 0) ? -128'sd1 : a_u / b_u;
			// zero divisor hands back the dividend
			mdu_pkg::OP_REM:    full = (b_u == 0) ? a_s : a_s % b_s;
			default:            full = (b_u == 0) ? a_u : a_u % b_u;
		endcase
		val = full[`MDU_XLEN-1:0];
		if (short_op(r))
			val = {{32{val[31]}}, val[31:0]};
		return val;
	endfunction

	// **************************************************
	// port monitor
	// **************************************************
	always @(posedge clk) begin
		cycle++;
		if (rst) begin
			pend.delete();
			if (cycle > 1 && (busy || done)) begin
				$display("busy or done high during reset at %0t", $time);
				n_other++;
			end
		end else begin
			if (pend.size() > 0 && !busy) begin
				$display("busy dropped at %0t while an operation was in flight", $time);
				n_other++;
			end
			if (done) begin
				if (pend.size() == 0) begin
					$display("done at %0t with no operation in flight", $time);
					n_other++;
				end else begin
					head = pend.pop_front();
					n_check++;
					if (result !== head.value) begin
						$display("mismatch at %0t: result %s word=%0b a=%h b=%h exp %h got %h",
							$time, head.req.op.name(), head.req.word, head.req.src_a,
							head.req.src_b, head.value, result);
						n_mis++;
					end
					if (cycle - int'(head.start_cycle) != int'(head.latency)) begin
						$display("done for %s at %0t came %0d cycles after start, expected %0d",
							head.req.op.name(), $time, cycle - int'(head.start_cycle),
							head.latency);
						n_other++;
					end
				end
			end
			if (flush && pend.size() > 0) begin
				pend.delete();
				n_flush++;
			end
			// overdue, drop it so the error is reported once
			if (pend.size() > 0 && cycle - int'(pend[0].start_cycle) > int'(pend[0].latency)) begin
				$display("no done for %s within %0d cycles, seen at %0t",
					pend[0].req.op.name(), pend[0].latency, $time);
				pend.delete();
				n_other++;
			end
			if (start && !flush) begin
				if (pend.size() == 0) begin
					head.req         = req;
					head.value       = expected_value(req);
					head.latency     = expected_latency(req);
					head.start_cycle = 32'(cycle);
					pend.push_back(head);
					n_accept++;
				end else begin
					n_ignore++;
				end
			end
			if (end_test && pend.size() > 0) begin
				$display("operation still in flight at end of test, %0t", $time);
				n_other++;
			end
		end
	end

endmodule

`default_nettype wire

/* tests/tb_npc_mdu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mdu_macros.svh"

module tb_npc_mdu #(
	parameter int unsigned SEED = 77
);

	localparam int N_OPS      = 300;
	// worst op is 66 cycles plus a few of setup and flush
	localparam int MAX_CYCLES = N_OPS * 80 + 500;

	logic                 clk;
	logic                 rst;
	logic                 start;
	logic                 flush;
	logic                 end_test;
	mdu_pkg::mdu_req_t    req;
	logic                 busy;
	logic                 done;
	logic [`MDU_XLEN-1:0] result;
	int                   mismatches;
	int                   other_errors;
	int                   checked;
	int                   flushed;
	int                   ignored;
	int                   accepted;
	int                   run_errors;
	int                   cycles;
	logic                 do_flush;

	npc_mdu i_dut (
		.clk    (clk),
		.rst    (rst),
		.start  (start),
		.flush  (flush),
		.req    (req),
		.busy   (busy),
		.done   (done),
		.result (result)
	);

	mdu_checker i_checker (
		.clk          (clk),
		.rst          (rst),
		.start        (start),
		.flush        (flush),
		.req          (req),
		.busy         (busy),
		.done         (done),
		.result       (result),
		.end_test     (end_test),
		.mismatches   (mismatches),
		.other_errors (other_errors),
		.checked      (checked),
		.flushed      (flushed),
		.ignored      (ignored),
		.accepted     (accepted)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// **************************************************
	// random operands
	// **************************************************

	// corner values mixed in with plain random words
	function automatic logic [`MDU_XLEN-1:0] pick_operand();
		case ($urandom_range(9, 0))
			0: return '0;
			1: return '1;
			2: return 64'h8000_0000_0000_0000;
			// most negative word value
			3: return 64'hffff_ffff_8000_0000;
			4: return {32'h0, $urandom()};
			default: return {$urandom(), $urandom()};
		endcase
	endfunction

	function automatic mdu_pkg::mdu_req_t random_request();
		mdu_pkg::mdu_req_t r;
		r.op    = mdu_pkg::mdu_op_e'(3'($urandom_range(7, 0)));
		r.word  = 1'($urandom_range(1, 0));
		r.src_a = pick_operand();
		r.src_b = pick_operand();
		// now and then a signed overflow pair, full or word
		if ($urandom_range(15, 0) == 0) begin
			r.op    = $urandom_range(1, 0) ? mdu_pkg::OP_DIV : mdu_pkg::OP_REM;
			r.src_a = r.word ? 64'hffff_ffff_8000_0000 : 64'h8000_0000_0000_0000;
			r.src_b = '1;
		end
		return r;
	endfunction

	// **************************************************
	// stimulus
	// **************************************************
	initial begin
		void'($urandom(SEED));
		rst        = 1'b1;
		start      = 1'b0;
		flush      = 1'b0;
		end_test   = 1'b0;
		req        = '0;
		run_errors = 0;
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		for (int n = 0; n < N_OPS; n++) begin
			while (busy)
				@(posedge clk);
			req   <= random_request();
			start <= 1'b1;
			@(posedge clk);
			start <= 1'b0;
			// junk on req, job must already be latched
			req      <= random_request();
			do_flush = ($urandom_range(19, 0) == 0);
			// extra start during busy, dropped by the DUT
			if ($urandom_range(7, 0) == 0) begin
				@(posedge clk);
				start <= 1'b1;
				@(posedge clk);
				start <= 1'b0;
			end
			if (do_flush) begin
				repeat ($urandom_range(4, 1)) @(posedge clk);
				flush <= 1'b1;
				@(posedge clk);
				flush <= 1'b0;
			end
			@(posedge clk);
		end
		while (busy)
			@(posedge clk);
		repeat (5) @(posedge clk);
		end_test <= 1'b1;
		@(posedge clk);
		end_test <= 1'b0;
		repeat (2) @(posedge clk);
		if (accepted != N_OPS) begin
			$display("only %0d of %0d operations were accepted", accepted, N_OPS);
			run_errors++;
		end
		$display("checked %0d, flushed %0d, ignored starts %0d, mismatches %0d, other errors %0d",
			checked, flushed, ignored, mismatches, other_errors + run_errors);
		if (mismatches == 0 && other_errors == 0 && run_errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

	// watchdog on the whole run
	initial cycles = 0;
	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("checked %0d, flushed %0d, ignored starts %0d, mismatches %0d, other errors %0d",
				checked, flushed, ignored, mismatches, other_errors + 1);
			$display("STATUS: FAIL");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* npc_mdu.f */
+incdir+common
common/mdu_pkg.sv
mdu/mdu_decode.sv
mdu/mdu_shift_mul.sv
mdu/mdu_restoring_div.sv
mdu/mdu_result.sv
rtl/npc_mdu.sv
tests/mdu_checker.sv
tests/tb_npc_mdu.sv

/* Makefile */
# Verilator simulation of npc_mdu

VERILATOR ?= verilator
TOP       ?= tb_npc_mdu
SEED      ?= 77
LOG       ?= sim.log
FILELIST  ?= npc_mdu.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

PASS_MSG := STATUS: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator, run, search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP SEED LOG FILELIST BUILD_DIR VFLAGS"

test:
	rm -f $(LOG)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
